// ==== design/ecc_pkg.sv ====
// Shared widths, bit layout and read status codes for the SECDED protected RAM
package ecc_pkg;

  // User data and code widths
  localparam int DATA_WIDTH    = 8;
  localparam int PARITY_WIDTH  = 5;
  // Hamming parities only, without the overall parity bit
  localparam int HAMMING_WIDTH = PARITY_WIDTH - 1;
  // Stored word holds data in the upper bits and the code in the lower bits
  localparam int WORD_WIDTH    = DATA_WIDTH + PARITY_WIDTH;

  // Storage geometry
  localparam int ADDR_WIDTH    = 4;
  localparam int DEPTH         = 16;

  // Width of a Hamming position index, also the syndrome width
  localparam int POS_WIDTH     = 4;

  // Block positions taken by data bits 0 to 7
  // Powers of two are left free for the Hamming parities
  localparam logic [DATA_WIDTH-1:0][POS_WIDTH-1:0] DATA_POSITIONS = {
    4'd12, 4'd11, 4'd10, 4'd9, 4'd7, 4'd6, 4'd5, 4'd3
  };

  // Saturating event counter width
  localparam int COUNT_WIDTH   = 8;

  // Result of one read
  typedef enum logic [1:0] {
    ECC_OK            = 2'd0,
    ECC_CORRECTED     = 2'd1,
    ECC_UNCORRECTABLE = 2'd2
  } ecc_status_e;

endpackage

// ==== design/ecc_ram_top.sv ====
// SECDED protected RAM chaining the encoder, the word array and the corrector
`timescale 1ns/10ps

module ecc_ram_top (
  input  logic                           clk,
  input  logic                           rst_n,
  // Write request
  input  logic                           wr_strobe,
  input  logic [ecc_pkg::ADDR_WIDTH-1:0]  wr_addr,
  input  logic [ecc_pkg::DATA_WIDTH-1:0]  wr_data,
  input  logic [ecc_pkg::WORD_WIDTH-1:0]  inject_mask,
  // Read request
  input  logic                           rd_strobe,
  input  logic [ecc_pkg::ADDR_WIDTH-1:0]  rd_addr,
  // Read response, two cycles after the request
  output logic                           rd_valid,
  output logic [ecc_pkg::DATA_WIDTH-1:0]  rd_data,
  output ecc_pkg::ecc_status_e           rd_status,
  // Event counters
  output logic [ecc_pkg::COUNT_WIDTH-1:0] corrected_count,
  output logic [ecc_pkg::COUNT_WIDTH-1:0] uncorrectable_count
);

  // Encoder to storage
  logic                          enc_strobe;
  logic [ecc_pkg::ADDR_WIDTH-1:0] enc_addr;
  logic [ecc_pkg::WORD_WIDTH-1:0] enc_word;
  // Storage to corrector
  logic                          fetch_strobe;
  logic [ecc_pkg::WORD_WIDTH-1:0] fetch_word;

  // Write side, one cycle to encode
  hamming_encoder encoder (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .wr_strobe   ( wr_strobe   ),
    .wr_addr     ( wr_addr     ),
    .wr_data     ( wr_data     ),
    .inject_mask ( inject_mask ),
    .enc_strobe  ( enc_strobe  ),
    .enc_addr    ( enc_addr    ),
    .enc_word    ( enc_word    )
  );

  // Array with a registered read
  ecc_storage storage (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .enc_strobe   ( enc_strobe   ),
    .enc_addr     ( enc_addr     ),
    .enc_word     ( enc_word     ),
    .rd_strobe    ( rd_strobe    ),
    .rd_addr      ( rd_addr      ),
    .fetch_strobe ( fetch_strobe ),
    .fetch_word   ( fetch_word   )
  );

  // Read side, decode and register the result
  extended_hamming_corrector corrector (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .fetch_strobe        ( fetch_strobe        ),
    .fetch_word          ( fetch_word          ),
    .rd_valid            ( rd_valid            ),
    .rd_data             ( rd_data             ),
    .rd_status           ( rd_status           ),
    .corrected_count     ( corrected_count     ),
    .uncorrectable_count ( uncorrectable_count )
  );

endmodule

// ==== design/ecc_storage.sv ====
// Sixteen-entry array of protected words with a registered read port
`timescale 1ns/10ps

module ecc_storage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          enc_strobe,
  input  logic [ecc_pkg::ADDR_WIDTH-1:0] enc_addr,
  input  logic [ecc_pkg::WORD_WIDTH-1:0] enc_word,
  input  logic                          rd_strobe,
  input  logic [ecc_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic                          fetch_strobe,
  output logic [ecc_pkg::WORD_WIDTH-1:0] fetch_word
);

  // Word array, contents undefined until written
  logic [ecc_pkg::WORD_WIDTH-1:0] mem [ecc_pkg::DEPTH];

  // Write port
  // Same edge read returns the old word
  always_ff @(posedge clk) begin
    if (enc_strobe) begin
      mem[enc_addr] <= enc_word;
    end
  end

  // Read port, word held until the next read
  always_ff @(posedge clk) begin
    if (rd_strobe) begin
      fetch_word <= mem[rd_addr];
    end
  end

  // Fetch strobe trails the read request by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_strobe <= 1'b0;
    end else begin
      fetch_strobe <= rd_strobe;
    end
  end

endmodule

// ==== design/extended_hamming_corrector.sv ====
// Read stage that decodes the extended Hamming word, fixes single errors and counts events
`timescale 1ns/10ps

module extended_hamming_corrector (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           fetch_strobe,
  input  logic [ecc_pkg::WORD_WIDTH-1:0]  fetch_word,
  output logic                           rd_valid,
  output logic [ecc_pkg::DATA_WIDTH-1:0]  rd_data,
  output ecc_pkg::ecc_status_e           rd_status,
  output logic [ecc_pkg::COUNT_WIDTH-1:0] corrected_count,
  output logic [ecc_pkg::COUNT_WIDTH-1:0] uncorrectable_count
);

  // Stored word split into its two fields
  logic [ecc_pkg::DATA_WIDTH-1:0]   stored_data;
  logic [ecc_pkg::PARITY_WIDTH-1:0] stored_code;
  // Block in Hamming position order, position 0 holds the overall parity
  logic [ecc_pkg::WORD_WIDTH-1:0]   block;
  logic [ecc_pkg::WORD_WIDTH-1:0]   fixed_block;
  logic [ecc_pkg::POS_WIDTH-1:0]    syndrome;
  logic                             overall_check;
  logic [ecc_pkg::DATA_WIDTH-1:0]   fixed_data;
  ecc_pkg::ecc_status_e             next_status;

  assign stored_data = fetch_word[ecc_pkg::WORD_WIDTH-1:ecc_pkg::PARITY_WIDTH];
  assign stored_code = fetch_word[ecc_pkg::PARITY_WIDTH-1:0];

  // Unpack into block positions
  always_comb begin
    block    = '0;
    block[0] = stored_code[0];
    // Hamming parity k sits at position 2^k
    for (int k = 0; k < ecc_pkg::HAMMING_WIDTH; k++) begin
      block[1 << k] = stored_code[k+1];
    end
    for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
      block[ecc_pkg::DATA_POSITIONS[i]] = stored_data[i];
    end
  end

  // Syndrome is the XOR of the indices of all set bits
  // Clean block gives zero since the parities cancel the data indices
  always_comb begin
    syndrome = '0;
    for (int p = 1; p < ecc_pkg::WORD_WIDTH; p++) begin
      if (block[p]) begin
        syndrome = syndrome ^ p[ecc_pkg::POS_WIDTH-1:0];
      end
    end
  end

  // Odd total means an odd number of flips, taken as a single one
  assign overall_check = ^block;

  // Flip the bit named by the syndrome
  // Zero syndrome lands on the overall parity and leaves the data alone
  always_comb begin
    fixed_block = block;
    if (overall_check && (int'(syndrome) < ecc_pkg::WORD_WIDTH)) begin
      fixed_block[syndrome] = ~block[syndrome];
    end
    for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
      fixed_data[i] = fixed_block[ecc_pkg::DATA_POSITIONS[i]];
    end
  end

  // Status decision
  always_comb begin
    if (overall_check) begin
      next_status = ecc_pkg::ECC_CORRECTED;
    end else if (syndrome != '0) begin
      // Even flips with a nonzero syndrome, raw data passes through
      next_status = ecc_pkg::ECC_UNCORRECTABLE;
    end else begin
      next_status = ecc_pkg::ECC_OK;
    end
  end

  // Result registers and saturating counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid            <= 1'b0;
      rd_status           <= ecc_pkg::ECC_OK;
      corrected_count     <= '0;
      uncorrectable_count <= '0;
    end else begin
      rd_valid <= fetch_strobe;
      if (fetch_strobe) begin
        rd_status <= next_status;
        // Counters stick at all ones
        if (next_status == ecc_pkg::ECC_CORRECTED && corrected_count != '1) begin
          corrected_count <= corrected_count + 1'b1;
        end
        if (next_status == ecc_pkg::ECC_UNCORRECTABLE && uncorrectable_count != '1) begin
          uncorrectable_count <= uncorrectable_count + 1'b1;
        end
      end
    end
  end

  // Data is payload, loaded only with a valid fetch
  always_ff @(posedge clk) begin
    if (fetch_strobe) begin
      rd_data <= fixed_data;
    end
  end

endmodule

// ==== design/hamming_encoder.sv ====
// Write stage computing the extended Hamming code and registering the masked stored word
`timescale 1ns/10ps

module hamming_encoder (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr_strobe,
  input  logic [ecc_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic [ecc_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic [ecc_pkg::WORD_WIDTH-1:0] inject_mask,
  output logic                          enc_strobe,
  output logic [ecc_pkg::ADDR_WIDTH-1:0] enc_addr,
  output logic [ecc_pkg::WORD_WIDTH-1:0] enc_word
);

  // Data spread over its Hamming positions, parity positions stay zero
  logic [ecc_pkg::WORD_WIDTH-1:0]    data_block;
  logic [ecc_pkg::HAMMING_WIDTH-1:0] ham_parity;
  logic                              overall_parity;
  logic [ecc_pkg::WORD_WIDTH-1:0]    packed_word;

  // Place data bits at their block positions
  always_comb begin
    data_block = '0;
    for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
      data_block[ecc_pkg::DATA_POSITIONS[i]] = wr_data[i];
    end
  end

  // Parity k covers every position whose index has bit k set
  // Only data positions are nonzero here so no parity feeds another
  always_comb begin
    ham_parity = '0;
    for (int k = 0; k < ecc_pkg::HAMMING_WIDTH; k++) begin
      for (int p = 1; p < ecc_pkg::WORD_WIDTH; p++) begin
        if (p[k]) begin
          ham_parity[k] = ham_parity[k] ^ data_block[p];
        end
      end
    end
  end

  // Overall parity over positions 1 to 12 makes the whole block even
  assign overall_parity = (^data_block) ^ (^ham_parity);

  // Code bit 0 is the overall parity, bits 1 to 4 the Hamming parities
  assign packed_word = {wr_data, ham_parity, overall_parity};

  // Strobe trails the write request by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enc_strobe <= 1'b0;
    end else begin
      enc_strobe <= wr_strobe;
    end
  end

  // Payload only moves on a write, fault mask applied on the way to storage
  always_ff @(posedge clk) begin
    if (wr_strobe) begin
      enc_addr <= wr_addr;
      enc_word <= packed_word ^ inject_mask;
    end
  end

endmodule

// ==== flist.f ====
design/ecc_pkg.sv
design/hamming_encoder.sv
design/ecc_storage.sv
design/extended_hamming_corrector.sv
design/ecc_ram_top.sv
sim/ecc_ram_asserts.sv
sim/ecc_ram_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SECDED RAM simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module ecc_ram_tb \
  -o ecc_ram_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ecc_ram_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

// ==== sim/ecc_ram_asserts.sv ====
// Bound checks on read latency, status encoding and event counter behavior
`timescale 1ns/10ps

module ecc_ram_asserts (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            rd_strobe,
  input logic                            rd_valid,
  input ecc_pkg::ecc_status_e            rd_status,
  input logic [ecc_pkg::COUNT_WIDTH-1:0] corrected_count,
  input logic [ecc_pkg::COUNT_WIDTH-1:0] uncorrectable_count
);

  // Response arrives exactly two cycles after the request
  read_latency: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid == $past(rd_strobe, 2))
    else $error("rd_valid does not follow rd_strobe by two cycles");

  // Code 3 is unused
  status_legal: assert property (@(posedge clk) disable iff (!rst_n)
    rd_status inside {ecc_pkg::ECC_OK, ecc_pkg::ECC_CORRECTED, ecc_pkg::ECC_UNCORRECTABLE})
    else $error("rd_status holds an undefined code");

  // Saturating counters only move up
  corrected_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
    corrected_count >= $past(corrected_count))
    else $error("corrected_count decreased");

  uncorrectable_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
    uncorrectable_count >= $past(uncorrectable_count))
    else $error("uncorrectable_count decreased");

endmodule

bind ecc_ram_top ecc_ram_asserts asserts (
  .clk                 ( clk                 ),
  .rst_n               ( rst_n               ),
  .rd_strobe           ( rd_strobe           ),
  .rd_valid            ( rd_valid            ),
  .rd_status           ( rd_status           ),
  .corrected_count     ( corrected_count     ),
  .uncorrectable_count ( uncorrectable_count )
);

// ==== sim/ecc_ram_tb.sv ====
// Table-driven testbench for the SECDED protected RAM with LFSR data and a reference model
`timescale 1ns/10ps

module ecc_ram_tb;

  typedef enum logic {OP_WRITE, OP_READ} op_e;

  // One row of the stimulus table
  typedef struct packed {
    op_e                              op;
    logic [ecc_pkg::ADDR_WIDTH-1:0]   addr;
    logic                             use_lfsr;
    logic [ecc_pkg::DATA_WIDTH-1:0]   data;
    logic [ecc_pkg::WORD_WIDTH-1:0]   mask;
    ecc_pkg::ecc_status_e             status;
  } entry_t;

  // Outstanding read, what it should return and when
  typedef struct packed {
    logic [ecc_pkg::DATA_WIDTH-1:0] data;
    ecc_pkg::ecc_status_e           status;
    // Cycle count at which rd_valid is due
    int                             due;
  } read_t;

  logic                            clk = 1'b0;
  logic                            rst_n;
  logic                            wr_strobe;
  logic [ecc_pkg::ADDR_WIDTH-1:0]  wr_addr;
  logic [ecc_pkg::DATA_WIDTH-1:0]  wr_data;
  logic [ecc_pkg::WORD_WIDTH-1:0]  inject_mask;
  logic                            rd_strobe;
  logic [ecc_pkg::ADDR_WIDTH-1:0]  rd_addr;
  logic                            rd_valid;
  logic [ecc_pkg::DATA_WIDTH-1:0]  rd_data;
  ecc_pkg::ecc_status_e            rd_status;
  logic [ecc_pkg::COUNT_WIDTH-1:0] corrected_count;
  logic [ecc_pkg::COUNT_WIDTH-1:0] uncorrectable_count;

  entry_t stim_table[$];
  read_t  pending_q[$];
  // Clean data and injected mask per address
  logic [ecc_pkg::DATA_WIDTH-1:0]  model_data [ecc_pkg::DEPTH];
  logic [ecc_pkg::WORD_WIDTH-1:0]  model_mask [ecc_pkg::DEPTH];
  logic [ecc_pkg::COUNT_WIDTH-1:0] exp_corrected = '0;
  logic [ecc_pkg::COUNT_WIDTH-1:0] exp_uncorrectable = '0;
  logic [7:0] lfsr_state = 8'd35;
  int data_errors = 0;
  int status_errors = 0;
  int count_errors = 0;
  int valid_errors = 0;
  int cycle_count = 0;
  int cycle_limit = 1000;

  ecc_ram_top UUT (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .wr_strobe           ( wr_strobe           ),
    .wr_addr             ( wr_addr             ),
    .wr_data             ( wr_data             ),
    .inject_mask         ( inject_mask         ),
    .rd_strobe           ( rd_strobe           ),
    .rd_addr             ( rd_addr             ),
    .rd_valid            ( rd_valid            ),
    .rd_data             ( rd_data             ),
    .rd_status           ( rd_status           ),
    .corrected_count     ( corrected_count     ),
    .uncorrectable_count ( uncorrectable_count )
  );

  // 40 ns period
  always #20 clk = ~clk;

  // Run limit, counted in rising edges
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d reads still outstanding",
               cycle_count, pending_q.size());
      $display("Test failed");
      $finish;
    end
  end

  // Galois form, taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] next_lfsr(input logic [7:0] state);
    if (state[0]) begin
      next_lfsr = (state >> 1) ^ 8'hB8;
    end else begin
      next_lfsr = state >> 1;
    end
  endfunction

  // One LFSR step per data bit
  task automatic draw_random_byte(output logic [ecc_pkg::DATA_WIDTH-1:0] value);
    for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
      value[i]   = lfsr_state[0];
      lfsr_state = next_lfsr(lfsr_state);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
      valid_errors++;
    end
  endtask

  task automatic check_data(input string name, input logic [ecc_pkg::DATA_WIDTH-1:0] exp,
                            input logic [ecc_pkg::DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      data_errors++;
    end
  endtask

  task automatic check_status(input string name, input ecc_pkg::ecc_status_e exp,
                              input ecc_pkg::ecc_status_e act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %s got %s", $time, name, exp.name(), act.name());
      status_errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [ecc_pkg::COUNT_WIDTH-1:0] exp,
                             input logic [ecc_pkg::COUNT_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
      count_errors++;
    end
  endtask

  task automatic add_entry(input op_e op, input logic [ecc_pkg::ADDR_WIDTH-1:0] addr,
                           input logic use_lfsr, input logic [ecc_pkg::DATA_WIDTH-1:0] data,
                           input logic [ecc_pkg::WORD_WIDTH-1:0] mask,
                           input ecc_pkg::ecc_status_e status);
    entry_t e;
    e.op       = op;
    e.addr     = addr;
    e.use_lfsr = use_lfsr;
    e.data     = data;
    e.mask     = mask;
    e.status   = status;
    stim_table.push_back(e);
  endtask

  task automatic build_table();
    logic [ecc_pkg::WORD_WIDTH-1:0] one_hot;
    // Clean fill of every address, then read all back
    for (int a = 0; a < ecc_pkg::DEPTH; a++) begin
      add_entry(OP_WRITE, a[ecc_pkg::ADDR_WIDTH-1:0], 1'b1, '0, '0, ecc_pkg::ECC_OK);
    end
    for (int a = 0; a < ecc_pkg::DEPTH; a++) begin
      add_entry(OP_READ, a[ecc_pkg::ADDR_WIDTH-1:0], 1'b0, '0, '0, ecc_pkg::ECC_OK);
    end
    // Single flip at every stored bit, address b carries bit b
    for (int b = 0; b < ecc_pkg::WORD_WIDTH; b++) begin
      one_hot    = '0;
      one_hot[b] = 1'b1;
      add_entry(OP_WRITE, b[ecc_pkg::ADDR_WIDTH-1:0], 1'b1, '0, one_hot, ecc_pkg::ECC_OK);
    end
    for (int b = 0; b < ecc_pkg::WORD_WIDTH; b++) begin
      add_entry(OP_READ, b[ecc_pkg::ADDR_WIDTH-1:0], 1'b0, '0, '0, ecc_pkg::ECC_CORRECTED);
    end
    // Double flips: overall plus Hamming, two data bits, data plus Hamming
    add_entry(OP_WRITE, 4'd13, 1'b0, 8'hA5, 13'h0003, ecc_pkg::ECC_OK);
    add_entry(OP_WRITE, 4'd14, 1'b0, 8'h3C, 13'h0120, ecc_pkg::ECC_OK);
    add_entry(OP_WRITE, 4'd15, 1'b0, 8'hFF, 13'h1010, ecc_pkg::ECC_OK);
    add_entry(OP_READ, 4'd13, 1'b0, '0, '0, ecc_pkg::ECC_UNCORRECTABLE);
    add_entry(OP_READ, 4'd14, 1'b0, '0, '0, ecc_pkg::ECC_UNCORRECTABLE);
    add_entry(OP_READ, 4'd15, 1'b0, '0, '0, ecc_pkg::ECC_UNCORRECTABLE);
    // Clean rewrite then a burst of reads with mixed status
    add_entry(OP_WRITE, 4'd5, 1'b0, 8'h5A, '0, ecc_pkg::ECC_OK);
    add_entry(OP_READ, 4'd15, 1'b0, '0, '0, ecc_pkg::ECC_UNCORRECTABLE);
    add_entry(OP_READ, 4'd2, 1'b0, '0, '0, ecc_pkg::ECC_CORRECTED);
    add_entry(OP_READ, 4'd5, 1'b0, '0, '0, ecc_pkg::ECC_OK);
    add_entry(OP_READ, 4'd14, 1'b0, '0, '0, ecc_pkg::ECC_UNCORRECTABLE);
  endtask

  // Drive one table row, expectation comes from the model and the mask popcount
  task automatic apply_entry(input entry_t e);
    logic [ecc_pkg::DATA_WIDTH-1:0] value;
    read_t                          exp;
    int                             flips;
    wr_strobe = 1'b0;
    rd_strobe = 1'b0;
    if (e.op == OP_WRITE) begin
      value = e.data;
      if (e.use_lfsr) begin
        draw_random_byte(value);
      end
      model_data[e.addr] = value;
      model_mask[e.addr] = e.mask;
      wr_addr     = e.addr;
      wr_data     = value;
      inject_mask = e.mask;
      wr_strobe   = 1'b1;
    end else begin
      flips      = $countones(model_mask[e.addr]);
      exp.data   = model_data[e.addr];
      exp.status = e.status;
      // Two cycle read latency
      exp.due    = cycle_count + 2;
      if (flips == 1) begin
        exp_corrected++;
      end else if (flips == 2) begin
        // Raw data field passes through with its flips
        exp.data = exp.data ^
                   model_mask[e.addr][ecc_pkg::WORD_WIDTH-1:ecc_pkg::PARITY_WIDTH];
        exp_uncorrectable++;
      end
      pending_q.push_back(exp);
      rd_addr   = e.addr;
      rd_strobe = 1'b1;
    end
  endtask

  // Responses come back in request order, each exactly on its due cycle
  task automatic sample_outputs();
    read_t exp;
    if (pending_q.size() != 0 && pending_q[0].due == cycle_count) begin
      exp = pending_q.pop_front();
      check_valid("rd_valid", 1'b1, rd_valid);
      check_data("rd_data", exp.data, rd_data);
      check_status("rd_status", exp.status, rd_status);
    end else begin
      check_valid("rd_valid", 1'b0, rd_valid);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    wr_strobe   = 1'b0;
    wr_addr     = '0;
    wr_data     = '0;
    inject_mask = '0;
    rd_strobe   = 1'b0;
    rd_addr     = '0;
    build_table();
    cycle_limit = 4 * stim_table.size() + 20;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // Idle outputs before any traffic
    @(negedge clk);
    check_valid("rd_valid", 1'b0, rd_valid);
    check_count("corrected_count", '0, corrected_count);
    check_count("uncorrectable_count", '0, uncorrectable_count);
    foreach (stim_table[i]) begin
      @(negedge clk);
      sample_outputs();
      apply_entry(stim_table[i]);
    end
    @(negedge clk);
    sample_outputs();
    wr_strobe = 1'b0;
    rd_strobe = 1'b0;
    // Drain the pipeline
    while (pending_q.size() != 0) begin
      @(negedge clk);
      sample_outputs();
    end
    check_count("corrected_count", exp_corrected, corrected_count);
    check_count("uncorrectable_count", exp_uncorrectable, uncorrectable_count);
    $display("Errors: data %0d, status %0d, count %0d, valid %0d",
             data_errors, status_errors, count_errors, valid_errors);
    if (data_errors + status_errors + count_errors + valid_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
